// File: logic/collision_checker.sv
`timescale 1ns/100ps

module collision_checker #(
	parameter int SCREEN_W = 640,                          // Pixels across
	parameter int SCREEN_H = 480                           // Pixels down
) (
	input  game_pkg::coord_word_u pos,                     // Player top left
	input  game_pkg::coord_word_u size,                    // Player w/h
	input  game_pkg::coord_word_u stage_pos,               // Stage top left
	input  game_pkg::coord_word_u stage_size,              // Stage w/h
	output game_pkg::coll_t       coll
);

	import game_pkg::*;

	localparam logic [COORD_W:0] SCR_W = (COORD_W+1)'(SCREEN_W);
	localparam logic [COORD_W:0] SCR_H = (COORD_W+1)'(SCREEN_H);

	logic [COORD_W:0] p_right;                             // Extra bit keeps the carry
	logic [COORD_W:0] p_bottom;
	logic [COORD_W:0] s_right;
	logic             x_overlap;                           // Spans share a column

	assign p_right  = {1'b0, pos.xy.x} + {1'b0, size.xy.x};
	assign p_bottom = {1'b0, pos.xy.y} + {1'b0, size.xy.y};
	assign s_right  = {1'b0, stage_pos.xy.x} + {1'b0, stage_size.xy.x};

	assign x_overlap = ({1'b0, pos.xy.x} < s_right) && (p_right > {1'b0, stage_pos.xy.x});

	always_comb begin
		coll = '0;
		coll[COLL_GROUND] = x_overlap
			&& (p_bottom >= {1'b0, stage_pos.xy.y})         // Feet at or past the top
			&& (pos.xy.y <= stage_pos.xy.y);                 // Head still above it
		coll[COLL_LEFT]   = (pos.xy.x == '0);
		coll[COLL_RIGHT]  = (p_right >= SCR_W);
		coll[COLL_FALLEN] = ({1'b0, pos.xy.y} >= SCR_H);
	end

endmodule

// File: logic/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
	parameter int DMEM_AW = 12                             // Word address bits, 12 at most
) (
	input  logic               clock,
	input  logic               we,                         // Already gated to low half
	input  logic [DMEM_AW-1:0] addr,
	input  logic [31:0]        wdata,
	output logic [31:0]        rdata
);

	localparam int DEPTH = 1 << DMEM_AW;

	logic [31:0] mem [DEPTH];                              // Contents undefined at power up

	// Old word comes out when reading the address being written
	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];                                  // Registered read
	end

endmodule

// File: logic/game_mmio_top.sv
`timescale 1ns/100ps

module game_mmio_top #(
	parameter int SCREEN_W     = 640,
	parameter int SCREEN_H     = 480,
	parameter int FRAME_CYCLES = 1024,                     // Clocks per game frame
	parameter int DMEM_AW      = 12                        // 12 max, bit 12 picks the half
) (
	input  logic        clock,
	input  logic        rst_n,
	input  logic [12:0] address,                           // Word address
	input  logic [31:0] data_in,
	input  logic        wren,
	output logic [31:0] data_out                           // One clock after address
);

	import game_pkg::*;

	logic [COORD_W-1:0] grav_p1, grav_p2;
	logic [COORD_W-1:0] move_p1, move_p2;
	coord_word_u        start_p1, start_p2;
	coord_word_u        size_p1, size_p2;
	coord_word_u        stage_pos, stage_size;             // Shared by both checkers
	coord_word_u        pos_p1, pos_p2;
	coll_t              coll_p1, coll_p2;
	logic               start_load_p1, start_load_p2;
	logic               frame_tick;
	logic               ram_we;
	logic               reg_space;                         // Registered address[12]
	logic [31:0]        reg_rdata;
	logic [31:0]        ram_rdata;

	mmio_regs #(.FRAME_CYCLES(FRAME_CYCLES)) mmio_regs_inst (
		.clock(clock), .rst_n(rst_n),
		.address(address), .data_in(data_in), .wren(wren),
		.pos_p1(pos_p1), .pos_p2(pos_p2), .coll_p1(coll_p1), .coll_p2(coll_p2),
		.grav_p1(grav_p1), .grav_p2(grav_p2), .move_p1(move_p1), .move_p2(move_p2),
		.start_p1(start_p1), .start_p2(start_p2), .size_p1(size_p1), .size_p2(size_p2),
		.stage_pos(stage_pos), .stage_size(stage_size),
		.start_load_p1(start_load_p1), .start_load_p2(start_load_p2),
		.frame_tick(frame_tick), .ram_we(ram_we),
		.reg_space(reg_space), .reg_rdata(reg_rdata)
	);

	// Player 1
	physics_unit physics_p1_inst (
		.clock(clock), .rst_n(rst_n),
		.grav(grav_p1), .move(move_p1), .start(start_p1), .start_load(start_load_p1),
		.frame_tick(frame_tick), .coll(coll_p1), .pos(pos_p1)
	);

	collision_checker #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) coll_p1_inst (
		.pos(pos_p1), .size(size_p1),
		.stage_pos(stage_pos), .stage_size(stage_size), .coll(coll_p1)
	);

	// Player 2
	physics_unit physics_p2_inst (
		.clock(clock), .rst_n(rst_n),
		.grav(grav_p2), .move(move_p2), .start(start_p2), .start_load(start_load_p2),
		.frame_tick(frame_tick), .coll(coll_p2), .pos(pos_p2)
	);

	collision_checker #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) coll_p2_inst (
		.pos(pos_p2), .size(size_p2),
		.stage_pos(stage_pos), .stage_size(stage_size), .coll(coll_p2)
	);

	data_ram #(.DMEM_AW(DMEM_AW)) data_ram_inst (
		.clock(clock), .we(ram_we),
		.addr(address[DMEM_AW-1:0]),                         // Upper low-half bits ignored
		.wdata(data_in), .rdata(ram_rdata)
	);

	// Both sources carry one clock of latency
	assign data_out = reg_space ? reg_rdata : ram_rdata;

endmodule

// File: logic/game_pkg.sv
package game_pkg;

	localparam int COORD_W = 16;                     // One screen coordinate

	// Screen pixels, x in the upper half of the bus word
	typedef struct packed {
		logic [COORD_W-1:0] x;                       // Column, unsigned
		logic [COORD_W-1:0] y;                       // Row, grows downward
	} coord_t;

	// Bus side writes raw and the game logic reads the x/y view
	typedef union packed {
		logic [2*COORD_W-1:0] raw;                   // Word as written
		coord_t               xy;                    // Decoded pair
	} coord_word_u;

	typedef logic [3:0] coll_t;                      // Collision flags

	localparam int COLL_GROUND = 0;                  // Standing on stage
	localparam int COLL_LEFT   = 1;                  // At left screen edge
	localparam int COLL_RIGHT  = 2;                  // At right screen edge
	localparam int COLL_FALLEN = 3;                  // Below the screen

	// Unit codes on address bits 11:7
	localparam logic [4:0] UNIT_P1     = 5'd0;
	localparam logic [4:0] UNIT_P2     = 5'd1;
	localparam logic [4:0] UNIT_STAGE  = 5'd2;
	localparam logic [4:0] UNIT_STATUS = 5'd3;

	// Player registers on address bits 6:2
	localparam logic [4:0] REG_GRAV  = 5'd0;         // Fall step per tick
	localparam logic [4:0] REG_START = 5'd1;         // Spawn point, reloads pos
	localparam logic [4:0] REG_MOVE  = 5'd2;         // Signed x step per tick
	localparam logic [4:0] REG_POS   = 5'd3;         // Read only
	localparam logic [4:0] REG_SIZE  = 5'd4;         // Width and height

	// Stage unit
	localparam logic [4:0] REG_STAGE_POS  = 5'd0;
	localparam logic [4:0] REG_STAGE_SIZE = 5'd1;

	// Status unit, all read only
	localparam logic [4:0] REG_COLL_P1 = 5'd0;
	localparam logic [4:0] REG_COLL_P2 = 5'd1;
	localparam logic [4:0] REG_FRAME   = 5'd2;

endpackage

// File: logic/mmio_regs.sv
`timescale 1ns/100ps

module mmio_regs #(
	parameter int FRAME_CYCLES = 1024                        // Clocks per frame tick
) (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic [12:0]                     address,
	input  logic [31:0]                     data_in,
	input  logic                            wren,
	input  game_pkg::coord_word_u           pos_p1,
	input  game_pkg::coord_word_u           pos_p2,
	input  game_pkg::coll_t                 coll_p1,
	input  game_pkg::coll_t                 coll_p2,
	output logic [game_pkg::COORD_W-1:0]    grav_p1,
	output logic [game_pkg::COORD_W-1:0]    grav_p2,
	output logic [game_pkg::COORD_W-1:0]    move_p1,
	output logic [game_pkg::COORD_W-1:0]    move_p2,
	output game_pkg::coord_word_u           start_p1,
	output game_pkg::coord_word_u           start_p2,
	output game_pkg::coord_word_u           size_p1,
	output game_pkg::coord_word_u           size_p2,
	output game_pkg::coord_word_u           stage_pos,
	output game_pkg::coord_word_u           stage_size,
	output logic                            start_load_p1,
	output logic                            start_load_p2,
	output logic                            frame_tick,
	output logic                            ram_we,
	output logic                            reg_space,
	output logic [31:0]                     reg_rdata
);

	import game_pkg::*;

	localparam int TICK_W = (FRAME_CYCLES > 1) ? $clog2(FRAME_CYCLES) : 1;
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(FRAME_CYCLES - 1);

	logic [4:0]         unit_sel;                            // Address bits 11:7
	logic [4:0]         reg_sel;                             // Address bits 6:2
	logic               reg_wr;                              // Write into register half
	logic               is_player;                           // P1 or P2 unit addressed
	logic               pl;                                  // Player index, 0 is P1

	logic [COORD_W-1:0] grav_r [2];
	logic [COORD_W-1:0] move_r [2];
	coord_word_u        start_r [2];
	coord_word_u        size_r [2];
	logic [1:0]         load_r;                              // Per-player reload strobe

	logic [TICK_W-1:0]  tick_cnt;                            // Clocks into current frame
	logic [31:0]        frame_cnt;                           // Ticks since reset
	logic [31:0]        rd_word;                             // Next read word

	assign unit_sel  = address[11:7];
	assign reg_sel   = address[6:2];
	assign reg_wr    = wren & address[12];
	assign ram_we    = wren & ~address[12];                  // Only bit 12 test in the hub
	assign is_player = (unit_sel == UNIT_P1) || (unit_sel == UNIT_P2);
	assign pl        = unit_sel[0];                          // P1=0, P2=1

	// Player register file
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			grav_r     <= '{default: '0};
			move_r     <= '{default: '0};
			start_r    <= '{default: '0};
			size_r     <= '{default: '0};
			load_r     <= '0;
			stage_pos  <= '0;
			stage_size <= '0;
		end else begin
			load_r <= '0;                                    // Strobe lasts one clock
			if (reg_wr && is_player) begin
				case (reg_sel)
					REG_GRAV:  grav_r[pl] <= data_in[COORD_W-1:0];
					REG_START: begin
						start_r[pl].raw <= data_in;
						load_r[pl]      <= 1'b1;             // pos reloads next edge
					end
					REG_MOVE:  move_r[pl] <= data_in[COORD_W-1:0];
					REG_SIZE:  size_r[pl].raw <= data_in;
					default: ;                               // REG_POS is read only
				endcase
			end
			if (reg_wr && (unit_sel == UNIT_STAGE)) begin
				case (reg_sel)
					REG_STAGE_POS:  stage_pos.raw  <= data_in;
					REG_STAGE_SIZE: stage_size.raw <= data_in;
					default: ;
				endcase
			end
		end
	end

	// Frame timer
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			tick_cnt   <= '0;
			frame_tick <= 1'b0;
			frame_cnt  <= '0;
		end else begin
			frame_tick <= (tick_cnt == TICK_LAST);           // One pulse per period
			if (tick_cnt == TICK_LAST)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
			if (frame_tick)
				frame_cnt <= frame_cnt + 1'b1;               // Same edge as pos step
		end
	end

	// Read mux, zero for anything unmapped
	always_comb begin
		rd_word = '0;
		case (unit_sel)
			UNIT_P1, UNIT_P2: begin
				case (reg_sel)
					REG_GRAV:  rd_word = {{(32-COORD_W){1'b0}}, grav_r[pl]};
					REG_START: rd_word = start_r[pl].raw;
					REG_MOVE:  rd_word = {{(32-COORD_W){1'b0}}, move_r[pl]};
					REG_POS:   rd_word = pl ? pos_p2.raw : pos_p1.raw;
					REG_SIZE:  rd_word = size_r[pl].raw;
					default: ;
				endcase
			end
			UNIT_STAGE: begin
				case (reg_sel)
					REG_STAGE_POS:  rd_word = stage_pos.raw;
					REG_STAGE_SIZE: rd_word = stage_size.raw;
					default: ;
				endcase
			end
			UNIT_STATUS: begin
				case (reg_sel)
					REG_COLL_P1: rd_word = {{(32-$bits(coll_t)){1'b0}}, coll_p1};
					REG_COLL_P2: rd_word = {{(32-$bits(coll_t)){1'b0}}, coll_p2};
					REG_FRAME:   rd_word = frame_cnt;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// One clock read latency, matches the RAM
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			reg_rdata <= '0;
			reg_space <= 1'b1;                               // Park on the zero register word
		end else begin
			reg_rdata <= rd_word;
			reg_space <= address[12];                        // Steers the top output mux
		end
	end

	assign grav_p1       = grav_r[0];
	assign grav_p2       = grav_r[1];
	assign move_p1       = move_r[0];
	assign move_p2       = move_r[1];
	assign start_p1      = start_r[0];
	assign start_p2      = start_r[1];
	assign size_p1       = size_r[0];
	assign size_p2       = size_r[1];
	assign start_load_p1 = load_r[0];
	assign start_load_p2 = load_r[1];

endmodule

// File: logic/physics_unit.sv
`timescale 1ns/100ps

module physics_unit (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic [game_pkg::COORD_W-1:0]    grav,        // Unsigned fall step
	input  logic [game_pkg::COORD_W-1:0]    move,        // Signed x step
	input  game_pkg::coord_word_u           start,
	input  logic                            start_load,
	input  logic                            frame_tick,
	input  game_pkg::coll_t                 coll,        // From own checker
	output game_pkg::coord_word_u           pos
);

	import game_pkg::*;

	logic        move_neg;                                 // Step goes left
	logic        blocked;                                  // Edge stops the x step
	coord_word_u next_pos;                                 // Position after one tick

	assign move_neg = move[COORD_W-1];

	// A zero move adds nothing whichever edge is checked
	assign blocked = move_neg ? coll[COLL_LEFT] : coll[COLL_RIGHT];

	// Step rule, flags come from the current pos
	always_comb begin
		next_pos = pos;
		if (coll[COLL_FALLEN]) begin
			next_pos = start;                                // Respawn
		end else begin
			if (!coll[COLL_GROUND]) begin
				next_pos.xy.y = pos.xy.y + grav;             // Wraps at 16 bits
			end
			if (!blocked) begin
				next_pos.xy.x = pos.xy.x + move;             // Two's complement add
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (start_load) begin
			pos <= start;                                    // Reload beats a tick
		end else if (frame_tick) begin
			pos <= next_pos;
		end
	end

endmodule

// File: tb.f
logic/game_pkg.sv
logic/data_ram.sv
logic/collision_checker.sv
logic/physics_unit.sv
logic/mmio_regs.sv
logic/game_mmio_top.sv
tb/tb_game_mmio.sv

// File: tb/tb_game_mmio.sv
`timescale 1ns/100ps

module tb_game_mmio;

	import game_pkg::*;

	localparam int CLK_NS         = 8;
	localparam int SCREEN_W       = 640;
	localparam int SCREEN_H       = 480;
	localparam int FRAME_CYCLES   = 16;                           // Short frames for simulation
	localparam int TICK_NS        = FRAME_CYCLES * CLK_NS;
	localparam int TEST_COUNT     = 6;
	localparam int TICKS_PER_TEST = 24;                           // Longest test needs about 18
	localparam int WATCHDOG_NS    = TEST_COUNT * TICKS_PER_TEST * TICK_NS;

	localparam logic [31:0] PLAYER_SIZE = {16'd16, 16'd24};       // w, h
	localparam logic [31:0] STAGE_POS   = {16'd100, 16'd300};     // Stage top left
	localparam logic [31:0] STAGE_SIZE  = {16'd200, 16'd20};

	logic        clock;
	logic        rst_n;
	logic [12:0] address;
	logic [31:0] data_in;
	logic        wren;
	logic [31:0] data_out;

	logic [15:0] mdl_grav [2];                                    // Values last written
	logic [15:0] mdl_move [2];
	logic [31:0] mdl_start [2];
	logic [31:0] mdl_size [2];
	logic [31:0] mdl_stage_pos;
	logic [31:0] mdl_stage_size;

	int          test_num = 1;
	int          test_errs = 0;
	int          total_errs = 0;
	int          tests_failed = 0;
	int          checks = 0;
	int          respawns = 0;                                    // Respawns seen on the DUT
	int          i;
	int          p;
	int          k;
	logic [11:0] ram_addr [32];
	logic [31:0] ram_data [32];
	logic [31:0] rd;
	logic [31:0] last;
	coll_t       exp_coll;

	game_mmio_top #(
		.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H),
		.FRAME_CYCLES(FRAME_CYCLES), .DMEM_AW(12)
	) game_mmio_top_inst (
		.clock(clock), .rst_n(rst_n), .address(address),
		.data_in(data_in), .wren(wren), .data_out(data_out)
	);

	always #(CLK_NS / 2) clock = ~clock;

	// Expected flags straight from the box and edge rules
	function automatic coll_t ref_coll(input logic [31:0] pos, input logic [31:0] size,
			input logic [31:0] spos, input logic [31:0] ssize);
		int px, py, pw, ph, sx, sy, sw;
		coll_t c;
		px = int'(pos[31:16]);
		py = int'(pos[15:0]);
		pw = int'(size[31:16]);
		ph = int'(size[15:0]);
		sx = int'(spos[31:16]);
		sy = int'(spos[15:0]);
		sw = int'(ssize[31:16]);
		c = '0;
		c[COLL_GROUND] = (px < sx + sw) && (px + pw > sx) && (py + ph >= sy) && (py <= sy);
		c[COLL_LEFT]   = (px == 0);
		c[COLL_RIGHT]  = (px + pw >= SCREEN_W);
		c[COLL_FALLEN] = (py >= SCREEN_H);
		return c;
	endfunction

	// One frame of motion for a player
	function automatic logic [31:0] ref_step(input logic [31:0] pos, input logic [31:0] start,
			input logic [15:0] grav, input logic [15:0] move, input coll_t c);
		int x, y, dx;
		x = int'(pos[31:16]);
		y = int'(pos[15:0]);
		dx = int'($signed(move));                                 // Sign extended step
		if (c[COLL_FALLEN])
			return start;                                         // Respawn
		if (!c[COLL_GROUND])
			y = y + int'(grav);
		if (!((dx < 0 && c[COLL_LEFT]) || (dx > 0 && c[COLL_RIGHT])))
			x = x + dx;
		return {x[15:0], y[15:0]};                                // 16 bit wrap
	endfunction

	function automatic logic [12:0] reg_addr(input logic [4:0] unit, input logic [4:0] rsel);
		return {1'b1, unit, rsel, 2'b00};
	endfunction

	function automatic logic [4:0] unit_of(input int pl);
		return (pl == 0) ? UNIT_P1 : UNIT_P2;
	endfunction

	function automatic logic [31:0] case_start(input int kk);
		case (kk)
			0:       return {16'd150, 16'd276};                   // Feet on stage top
			1:       return {16'd0, 16'd100};                     // Left edge
			2:       return {16'(SCREEN_W - 16), 16'd100};        // Right edge
			default: return {16'd50, 16'(SCREEN_H)};              // Below the screen
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0d ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			test_errs++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errs == 0)
			$display("Test %0d %s: ok", test_num, name);
		else
			$display("Test %0d %s: %0d errors", test_num, name, test_errs);
		total_errs += test_errs;
		if (test_errs != 0)
			tests_failed++;
		test_errs = 0;
		test_num++;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	// Called on a falling edge, write lands at the next rising edge
	task automatic write_word(input logic [12:0] addr, input logic [31:0] data);
		address = addr;
		data_in = data;
		wren = 1'b1;
		@(negedge clock);
		wren = 1'b0;
	endtask

	task automatic read_word(input logic [12:0] addr, output logic [31:0] data);
		address = addr;
		wren = 1'b0;
		@(negedge clock);
		data = data_out;                                          // Registered one edge ago
	endtask

	task automatic write_reg(input logic [4:0] unit, input logic [4:0] rsel, input logic [31:0] d);
		write_word(reg_addr(unit, rsel), d);
	endtask

	task automatic read_reg(input logic [4:0] unit, input logic [4:0] rsel, output logic [31:0] d);
		read_word(reg_addr(unit, rsel), d);
	endtask

	task automatic check_unmapped(input logic [4:0] unit, input logic [4:0] rsel);
		logic [31:0] d;
		read_reg(unit, rsel, d);
		check_word($sformatf("unit %0d reg %0d", unit, rsel), d, 32'h0);
	endtask

	task automatic set_player(input int pl, input logic [15:0] grav, input logic [15:0] move,
			input logic [31:0] start, input logic [31:0] size);
		mdl_grav[pl] = grav;
		mdl_move[pl] = move;
		mdl_start[pl] = start;
		mdl_size[pl] = size;
		write_reg(unit_of(pl), REG_GRAV, {16'h0, grav});
		write_reg(unit_of(pl), REG_MOVE, {16'h0, move});
		write_reg(unit_of(pl), REG_SIZE, size);
		write_reg(unit_of(pl), REG_START, start);                 // Last, reload sees the rest
	endtask

	task automatic set_stage(input logic [31:0] spos, input logic [31:0] ssize);
		mdl_stage_pos = spos;
		mdl_stage_size = ssize;
		write_reg(UNIT_STAGE, REG_STAGE_POS, spos);
		write_reg(UNIT_STAGE, REG_STAGE_SIZE, ssize);
	endtask

	// Position with the frame count it belongs to
	task automatic read_stable(input int pl, output logic [31:0] frame, output logic [31:0] pos);
		logic [31:0] f0, f1;
		int tries;
		tries = 0;
		do begin
			read_reg(UNIT_STATUS, REG_FRAME, f0);
			read_reg(unit_of(pl), REG_POS, pos);
			read_reg(UNIT_STATUS, REG_FRAME, f1);
			tries++;
		end while (f0 != f1 && tries < 4);
		assert (f0 == f1) else begin
			$display("At %0d ns: frame count kept changing around a position read", $time);
			test_errs++;
		end
		frame = f0;
	endtask

	// Follow a player for n ticks after its reload, model stepped once per elapsed frame
	// Starts one clock after set_player, so the first frame read belongs to pos == start
	task automatic track_player(input int pl, input int n_ticks, output logic [31:0] last_pos);
		logic [31:0] f_base, f_prev, f, pos_r, prev_pos, mdl, step;
		coll_t c;
		read_reg(UNIT_STATUS, REG_FRAME, f_base);                 // Count after the reload edge
		mdl = mdl_start[pl];
		prev_pos = mdl_start[pl];
		f_prev = f_base;
		while (int'(f_prev - f_base) < n_ticks) begin
			read_stable(pl, f, pos_r);
			step = f - f_prev;
			assert (step <= 2) else begin
				$display("At %0d ns: frame count jumped from %0d to %0d", $time, f_prev, f);
				test_errs++;
				f_prev = f;
			end
			while (f_prev != f) begin
				c = ref_coll(mdl, mdl_size[pl], mdl_stage_pos, mdl_stage_size);
				mdl = ref_step(mdl, mdl_start[pl], mdl_grav[pl], mdl_move[pl], c);
				f_prev = f_prev + 1;
			end
			check_word($sformatf("pos_p%0d", pl + 1), pos_r, mdl);
			if (int'(prev_pos[15:0]) >= SCREEN_H && pos_r === mdl_start[pl])
				respawns++;                                       // Back at spawn from off screen
			prev_pos = pos_r;
		end
		last_pos = pos_r;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		address = '0;
		data_in = '0;
		wren = 1'b0;
		void'($urandom(32'hc244));                                // Seed once
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// RAM words survive writes to the register half with the same low bits
		for (i = 0; i < 32; i++) begin
			ram_addr[i] = {i[4:0], 7'($urandom)};                 // Upper bits keep them distinct
			ram_data[i] = $urandom;
			write_word({1'b0, ram_addr[i]}, ram_data[i]);
		end
		for (i = 0; i < 32; i++)
			write_word({1'b1, ram_addr[i]}, ~ram_data[i]);
		for (i = 0; i < 32; i++) begin
			read_word({1'b0, ram_addr[i]}, rd);
			check_word($sformatf("ram[%03h]", ram_addr[i]), rd, ram_data[i]);
		end
		finish_test("ram readback");

		for (p = 0; p < 2; p++)
			set_player(p, 16'($urandom), 16'($urandom), $urandom, $urandom);
		set_stage($urandom, $urandom);
		for (p = 0; p < 2; p++) begin
			read_reg(unit_of(p), REG_GRAV, rd);
			check_word($sformatf("grav_p%0d", p + 1), rd, {16'h0, mdl_grav[p]});
			read_reg(unit_of(p), REG_MOVE, rd);
			check_word($sformatf("move_p%0d", p + 1), rd, {16'h0, mdl_move[p]});
			read_reg(unit_of(p), REG_START, rd);
			check_word($sformatf("start_p%0d", p + 1), rd, mdl_start[p]);
			read_reg(unit_of(p), REG_SIZE, rd);
			check_word($sformatf("size_p%0d", p + 1), rd, mdl_size[p]);
		end
		read_reg(UNIT_STAGE, REG_STAGE_POS, rd);
		check_word("stage_pos", rd, mdl_stage_pos);
		read_reg(UNIT_STAGE, REG_STAGE_SIZE, rd);
		check_word("stage_size", rd, mdl_stage_size);
		check_unmapped(5'd4, 5'd0);
		check_unmapped(5'd31, 5'd31);
		check_unmapped(UNIT_P1, 5'd5);
		check_unmapped(UNIT_STAGE, 5'd2);
		check_unmapped(UNIT_STATUS, 5'd3);
		for (p = 0; p < 2; p++) begin
			set_player(p, 16'h0, 16'h0, $urandom, mdl_size[p]);  // Frozen, pos holds start
			idle(1);                                              // pos loads one edge after write
			read_reg(unit_of(p), REG_POS, rd);
			check_word($sformatf("pos_p%0d", p + 1), rd, mdl_start[p]);
		end
		finish_test("register map");

		set_stage(STAGE_POS, STAGE_SIZE);
		for (p = 0; p < 2; p++) begin
			for (k = 0; k < 4; k++) begin
				set_player(p, 16'h0, 16'h0, case_start(k), PLAYER_SIZE);
				idle(1);
				read_reg(UNIT_STATUS, (p == 0) ? REG_COLL_P1 : REG_COLL_P2, rd);
				exp_coll = ref_coll(case_start(k), PLAYER_SIZE, STAGE_POS, STAGE_SIZE);
				check_word($sformatf("coll_p%0d case %0d", p + 1, k), rd, {28'h0, exp_coll});
			end
		end
		finish_test("collision flags");

		set_player(0, 16'd7, 16'h0, {16'd150, 16'd200}, PLAYER_SIZE);  // Drops onto the stage
		idle(1);
		track_player(0, 16, last);
		read_reg(UNIT_STATUS, REG_COLL_P1, rd);
		exp_coll = ref_coll(last, mdl_size[0], mdl_stage_pos, mdl_stage_size);
		check_word("coll_p1", rd, {28'h0, exp_coll});
		assert (rd[COLL_GROUND]) else begin
			$display("At %0d ns: player 1 did not come to rest on the stage", $time);
			test_errs++;
		end
		finish_test("falling");

		respawns = 0;
		set_player(1, 16'd100, 16'h0, {16'd500, 16'd400}, PLAYER_SIZE);  // Off the stage
		idle(1);
		track_player(1, 3, last);
		assert (respawns > 0) else begin
			$display("At %0d ns: player 2 never returned to its start from below the screen",
				$time);
			test_errs++;
		end
		finish_test("respawn");

		set_player(0, 16'h0, 16'hfffb, {16'd0, 16'd100}, PLAYER_SIZE);            // Push left
		idle(1);
		track_player(0, 2, last);
		check_word("pos_p1 x", {16'h0, last[31:16]}, 32'h0);
		set_player(1, 16'h0, 16'd5, {16'(SCREEN_W - 16), 16'd120}, PLAYER_SIZE);  // Push right
		idle(1);
		track_player(1, 2, last);
		check_word("pos_p2 x", {16'h0, last[31:16]}, 32'(SCREEN_W - 16));
		finish_test("edge blocking");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			test_num - 1, tests_failed, checks, total_errs);
		if (total_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
